//--- logic/rv32_settings.svh
// RV32 multicycle core build settings
// widths, memory depth and reset vector shared by all blocks
`ifndef RV32_SETTINGS_SVH
`define RV32_SETTINGS_SVH

`define XLEN 32 // data and address width

`define MEM_WORDS 256 // unified memory depth in words

`define RESET_PC 32'h0000_0000 // first fetch address

`define REG_COUNT 32

`endif

//--- logic/rv32Pkg.sv
// RV32 multicycle core shared types
// opcodes, datapath selects, ALU operations, control word and trace events
`include "rv32_settings.svh"

package rv32Pkg;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    RType       = 7'b0110011,
    IType_logic = 7'b0010011,
    IType_load  = 7'b0000011,
    SType       = 7'b0100011,
    BType       = 7'b1100011,
    JType       = 7'b1101111,
    IType_jalr  = 7'b1100111,
    UType_lui   = 7'b0110111,
    UType_auipc = 7'b0010111
  } opcode_t;

  typedef enum logic {AdrPc, AdrResult} adrSrc_t;

  typedef enum logic [1:0] {SrcARd1, SrcAOldPc, SrcAZero} aluSrcA_t;

  typedef enum logic [1:0] {SrcBRd2, SrcBImm, SrcBFour} aluSrcB_t;

  typedef enum logic [1:0] {ResultAluOut, ResultData, ResultAlu} resultSrc_t;

  // jump uses the registered target, masked uses the live sum for jalr
  typedef enum logic [1:0] {PcIncrement, PcJump, PcAluMasked} pcSrc_t;

  typedef enum logic [1:0] {GroupAdd, GroupSub, GroupRType, GroupIType} aluGroup_t;

  typedef enum logic [3:0] {
    AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSll, AluSrl, AluSra, AluSlt, AluSltu
  } aluOp_t;

  typedef logic [$clog2(`MEM_WORDS)-1:0] wordAddr_t;

  typedef struct packed {
    adrSrc_t    adrSrc;
    aluSrcA_t   aluSrcA;
    aluSrcB_t   aluSrcB;
    resultSrc_t resultSrc;
    pcSrc_t     pcSrc;
    logic       irWrite;
    logic       regWrite;
    logic       pcUpdate;
    logic       memWrite;
    logic       branch; // PC loads the target when zero is set
  } controlWord_t;

  typedef struct packed {
    logic [$clog2(`REG_COUNT)-1:0] rd;
    logic [`XLEN-1:0]              data;
  } wbEvent_t;

  typedef struct packed {
    wordAddr_t        wordAddr;
    logic [`XLEN-1:0] data;
  } storeEvent_t;

endpackage

//--- logic/controlFsm.sv
// RV32 control state machine
// steps each instruction through fetch, decode and its execute states
`timescale 1ns/10ps

module controlFsm (
  input  logic               clk,
  input  logic               reset,
  input  rv32Pkg::opcode_t   opcode,
  input  logic               zero,
  output rv32Pkg::controlWord_t ctrl,
  output rv32Pkg::aluGroup_t aluGroup
);
  import rv32Pkg::*;

  typedef enum logic [3:0] {
    fetch, decode, executeR, executeI, unconditionalJump, memAddress, memRead, memWrite,
    memWriteBack, aluWriteBack, branchIfEqual, lui, auipc, jalrCalc, jalrLink
  } state_t;

  state_t state, nextState;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fetch;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    case (state)
      fetch: nextState = decode;
      decode: begin
        case (opcode)
          RType:       nextState = executeR;
          IType_logic: nextState = executeI;
          IType_load:  nextState = memAddress;
          SType:       nextState = memAddress;
          BType:       nextState = branchIfEqual;
          JType:       nextState = unconditionalJump;
          IType_jalr:  nextState = jalrCalc;
          UType_lui:   nextState = lui;
          UType_auipc: nextState = auipc;
          default:     nextState = decode; // unknown opcode stalls here
        endcase
      end
      memAddress: nextState = (opcode == IType_load) ? memRead : memWrite;
      memRead: nextState = memWriteBack;
      jalrCalc: nextState = jalrLink;
      executeR, executeI, unconditionalJump, lui, auipc, jalrLink: nextState = aluWriteBack;
      default: nextState = fetch; // write-back, store and branch all end here
    endcase
  end

  always_comb begin
    ctrl = '0;
    ctrl.adrSrc = AdrPc;
    ctrl.aluSrcA = SrcARd1;
    ctrl.aluSrcB = SrcBRd2;
    ctrl.resultSrc = ResultAluOut;
    ctrl.pcSrc = PcIncrement;
    aluGroup = GroupAdd;
    case (state)
      decode: begin // branch and jal target into the ALU output register
        ctrl.aluSrcA = SrcAOldPc;
        ctrl.aluSrcB = SrcBImm;
      end
      executeR: begin
        aluGroup = GroupRType;
      end
      executeI: begin
        ctrl.aluSrcB = SrcBImm;
        aluGroup = GroupIType;
      end
      unconditionalJump: begin
        ctrl.aluSrcA = SrcAOldPc; // link value old PC + 4
        ctrl.aluSrcB = SrcBFour;
        ctrl.pcSrc = PcJump;
        ctrl.pcUpdate = 1'b1;
      end
      memAddress: begin
        ctrl.aluSrcB = SrcBImm;
      end
      memRead: begin
        ctrl.adrSrc = AdrResult;
      end
      memWrite: begin
        ctrl.adrSrc = AdrResult;
        ctrl.memWrite = 1'b1;
      end
      memWriteBack: begin
        ctrl.resultSrc = ResultData;
        ctrl.regWrite = 1'b1;
      end
      aluWriteBack: begin
        ctrl.regWrite = 1'b1;
      end
      branchIfEqual: begin
        aluGroup = GroupSub;
        ctrl.branch = 1'b1;
        ctrl.pcSrc = zero ? PcJump : PcIncrement;
      end
      lui: begin
        ctrl.aluSrcA = SrcAZero;
        ctrl.aluSrcB = SrcBImm;
      end
      auipc: begin
        ctrl.aluSrcA = SrcAOldPc;
        ctrl.aluSrcB = SrcBImm;
      end
      jalrCalc: begin // rs1 + imm straight into the PC
        ctrl.aluSrcB = SrcBImm;
        ctrl.pcSrc = PcAluMasked;
        ctrl.pcUpdate = 1'b1;
      end
      jalrLink: begin
        ctrl.aluSrcA = SrcAOldPc;
        ctrl.aluSrcB = SrcBFour;
      end
      default: begin // fetch and any unknown state
        ctrl.irWrite = 1'b1;
        ctrl.pcUpdate = 1'b1;
      end
    endcase
  end

endmodule

//--- logic/aluDecoder.sv
// ALU decoder
// turns the state machine's group and the function fields into an ALU operation
`timescale 1ns/10ps

module aluDecoder (
  input  rv32Pkg::aluGroup_t aluGroup,
  input  logic [2:0]         funct3,
  input  logic               funct7b5,
  input  logic               opcodeBit5,
  output rv32Pkg::aluOp_t    aluOp
);
  import rv32Pkg::*;

  logic subSel;

  // only register add has a subtract form
  assign subSel = (aluGroup == GroupRType) && opcodeBit5 && funct7b5;

  always_comb begin
    case (aluGroup)
      GroupAdd: aluOp = AluAdd;
      GroupSub: aluOp = AluSub;
      default: begin
        case (funct3)
          3'b000:  aluOp = subSel ? AluSub : AluAdd;
          3'b001:  aluOp = AluSll;
          3'b010:  aluOp = AluSlt;
          3'b011:  aluOp = AluSltu;
          3'b100:  aluOp = AluXor;
          3'b101:  aluOp = funct7b5 ? AluSra : AluSrl; // same bit for srai
          3'b110:  aluOp = AluOr;
          default: aluOp = AluAnd;
        endcase
      end
    endcase
  end

endmodule

//--- logic/immExtend.sv
// immediate extender
// picks the I, S, B, U or J layout from the opcode and sign-extends it
`timescale 1ns/10ps
`include "rv32_settings.svh"

module immExtend (
  input  logic [`XLEN-1:0] instr,
  output logic [`XLEN-1:0] imm
);
  import rv32Pkg::*;

  always_comb begin
    case (instr[6:0])
      IType_logic, IType_load, IType_jalr: imm = {{20{instr[31]}}, instr[31:20]};
      SType: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      BType: begin
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      JType: begin
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      UType_lui, UType_auipc: imm = {instr[31:12], 12'b0};
      default: imm = '0; // R-type carries no immediate
    endcase
  end

endmodule

//--- logic/alu.sv
// 32-bit ALU
// arithmetic, logic, shifts and compares, with a zero flag for beq
`timescale 1ns/10ps
`include "rv32_settings.svh"

module alu (
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  input  rv32Pkg::aluOp_t  op,
  output logic [`XLEN-1:0] y,
  output logic             zero
);
  import rv32Pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      AluSub:  y = a - b;
      AluAnd:  y = a & b;
      AluOr:   y = a | b;
      AluXor:  y = a ^ b;
      AluSll:  y = a << shamt;
      AluSrl:  y = a >> shamt;
      AluSra:  y = $signed(a) >>> shamt;
      AluSlt:  y = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      AluSltu: y = {{(`XLEN-1){1'b0}}, a < b};
      default: y = a + b;
    endcase
  end

  assign zero = (y == '0);

endmodule

//--- logic/datapath.sv
// multicycle datapath
// PC, instruction and result registers, register file, source muxes and trace outputs
`timescale 1ns/10ps
`include "rv32_settings.svh"

module datapath (
  input  logic                  clk,
  input  logic                  reset,
  input  rv32Pkg::controlWord_t ctrl,
  input  rv32Pkg::aluOp_t       aluOp,
  input  logic [`XLEN-1:0]      readData,
  output logic [`XLEN-1:0]      memAddr,
  output logic [`XLEN-1:0]      writeData,
  output logic                  memWe,
  output rv32Pkg::opcode_t      opcode,
  output logic [2:0]            funct3,
  output logic                  funct7b5,
  output logic                  zero,
  output logic                  wbValid,
  output rv32Pkg::wbEvent_t     wb,
  output logic                  storeValid,
  output rv32Pkg::storeEvent_t  store
);
  import rv32Pkg::*;

  localparam int RegBits = $clog2(`REG_COUNT);
  localparam int WordBits = $bits(wordAddr_t);

  logic [`XLEN-1:0] pc, oldPc, instr, aluOut, dataReg;
  logic [`XLEN-1:0] regFile [`REG_COUNT];
  logic [RegBits-1:0] rs1, rs2, rd;
  logic [`XLEN-1:0] rd1, rd2, immExt;
  logic [`XLEN-1:0] srcA, srcB, aluResult, result, pcNext;
  logic pcWrite;

  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign rd = instr[11:7];
  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7b5 = instr[30];

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RESET_PC;
    end else if (pcWrite) begin
      pc <= pcNext;
    end
  end

  // fetch captures the instruction and the address it came from
  always_ff @(posedge clk) begin
    if (ctrl.irWrite) begin
      oldPc <= pc;
      instr <= readData;
    end
  end

  always_ff @(posedge clk) begin
    aluOut <= aluResult;
    dataReg <= readData;
  end

  always_ff @(posedge clk) begin
    if (ctrl.regWrite && rd != '0) begin
      regFile[rd] <= result;
    end
  end

  assign rd1 = (rs1 == '0) ? '0 : regFile[rs1]; // x0 is hardwired
  assign rd2 = (rs2 == '0) ? '0 : regFile[rs2];

  immExtend i_immExtend (
    .instr (instr),
    .imm   (immExt)
  );

  always_comb begin
    case (ctrl.aluSrcA)
      SrcARd1:   srcA = rd1;
      SrcAOldPc: srcA = oldPc;
      default:   srcA = '0;
    endcase
    case (ctrl.aluSrcB)
      SrcBRd2: srcB = rd2;
      SrcBImm: srcB = immExt;
      default: srcB = `XLEN'(4);
    endcase
  end

  alu i_alu (
    .a    (srcA),
    .b    (srcB),
    .op   (aluOp),
    .y    (aluResult),
    .zero (zero)
  );

  always_comb begin
    case (ctrl.resultSrc)
      ResultAluOut: result = aluOut;
      ResultData:   result = dataReg;
      default:      result = aluResult;
    endcase
  end

  always_comb begin
    case (ctrl.pcSrc)
      PcJump:      pcNext = aluOut;
      PcAluMasked: pcNext = aluResult & ~`XLEN'(1); // jalr clears bit 0
      default:     pcNext = pc + `XLEN'(4);
    endcase
  end

  // a branch only moves the PC when the compare came out equal
  assign pcWrite = ctrl.pcUpdate | (ctrl.branch & zero);

  assign memAddr = (ctrl.adrSrc == AdrPc) ? pc : result;
  assign writeData = rd2;
  assign memWe = ctrl.memWrite;

  assign wbValid = ctrl.regWrite;
  assign wb = '{rd: rd, data: result};
  assign storeValid = ctrl.memWrite;
  assign store = '{wordAddr: memAddr[WordBits+1:2], data: rd2};

endmodule

//--- logic/unifiedMemory.sv
// unified instruction and data memory
// word array with combinational read and a load port for program download
`timescale 1ns/10ps
`include "rv32_settings.svh"

module unifiedMemory (
  input  logic               clk,
  input  logic [`XLEN-1:0]   addr,
  input  logic [`XLEN-1:0]   writeData,
  input  logic               we,
  input  logic               loadEn,
  input  rv32Pkg::wordAddr_t loadAddr,
  input  logic [`XLEN-1:0]   loadData,
  output logic [`XLEN-1:0]   readData
);

  localparam int WordBits = $clog2(`MEM_WORDS);

  logic [`XLEN-1:0] mem [`MEM_WORDS];
  logic [WordBits-1:0] wordIdx;

  assign wordIdx = addr[WordBits+1:2]; // byte address to word index

  always_ff @(posedge clk) begin
    if (loadEn) begin
      mem[loadAddr] <= loadData; // download wins over a core store
    end else if (we) begin
      mem[wordIdx] <= writeData;
    end
  end

  assign readData = mem[wordIdx];

endmodule

//--- logic/rv32Multicycle.sv
// RV32I multicycle core top level
// joins control FSM, ALU decoder, datapath and the unified memory
`timescale 1ns/10ps
`include "rv32_settings.svh"

module rv32Multicycle (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 loadEn,
  input  rv32Pkg::wordAddr_t   loadAddr,
  input  logic [`XLEN-1:0]     loadData,
  output logic                 wbValid,
  output rv32Pkg::wbEvent_t    wb,
  output logic                 storeValid,
  output rv32Pkg::storeEvent_t store
);
  import rv32Pkg::*;

  controlWord_t ctrl;
  aluGroup_t aluGroup;
  aluOp_t aluOp;
  opcode_t opcode;
  logic [2:0] funct3;
  logic funct7b5, zero, memWe;
  logic [`XLEN-1:0] memAddr, writeData, readData;

  controlFsm i_controlFsm (
    .clk      (clk),
    .reset    (reset),
    .opcode   (opcode),
    .zero     (zero),
    .ctrl     (ctrl),
    .aluGroup (aluGroup)
  );

  aluDecoder i_aluDecoder (
    .aluGroup   (aluGroup),
    .funct3     (funct3),
    .funct7b5   (funct7b5),
    .opcodeBit5 (opcode[5]),
    .aluOp      (aluOp)
  );

  datapath i_datapath (
    .clk        (clk),
    .reset      (reset),
    .ctrl       (ctrl),
    .aluOp      (aluOp),
    .readData   (readData),
    .memAddr    (memAddr),
    .writeData  (writeData),
    .memWe      (memWe),
    .opcode     (opcode),
    .funct3     (funct3),
    .funct7b5   (funct7b5),
    .zero       (zero),
    .wbValid    (wbValid),
    .wb         (wb),
    .storeValid (storeValid),
    .store      (store)
  );

  unifiedMemory i_unifiedMemory (
    .clk       (clk),
    .addr      (memAddr),
    .writeData (writeData),
    .we        (memWe),
    .loadEn    (loadEn),
    .loadAddr  (loadAddr),
    .loadData  (loadData),
    .readData  (readData)
  );

endmodule

//--- verif/traceMonitor.sv
// trace monitor
// compares write-back and store pulses against the expected event list
`timescale 1ns/10ps

module traceMonitor (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 wbValid,
  input  rv32Pkg::wbEvent_t    wb,
  input  logic                 storeValid,
  input  rv32Pkg::storeEvent_t store,
  output logic                 allSeen,
  output int                   errorCount
);
  import rv32Pkg::*;

  string names[$];
  bit isStores[$];
  logic [31:0] keys[$];
  logic [31:0] datas[$];
  int passCount;

  initial begin
    allSeen = 1'b0;
    errorCount = 0;
    passCount = 0;
  end

  task automatic addExpected(string name, bit isStore, logic [31:0] key, logic [31:0] data);
    names.push_back(name);
    isStores.push_back(isStore);
    keys.push_back(key);
    datas.push_back(data);
  endtask

  task automatic checkEvent(bit isStore, logic [31:0] key, logic [31:0] data);
    string name;
    bit expStore;
    logic [31:0] expKey;
    logic [31:0] expData;
    name = names.pop_front();
    expStore = isStores.pop_front();
    expKey = keys.pop_front();
    expData = datas.pop_front();
    if (isStore != expStore) begin
      errorCount++;
      $display("%s: got a %s pulse where a %s was expected", name,
               isStore ? "store" : "write-back", expStore ? "store" : "write-back");
    end else if (key !== expKey || data !== expData) begin
      errorCount++;
      $display("** Error %s: expected %0h:%08h, actual %0h:%08h", name, expKey, expData,
               key, data); // key is rd or word address
    end else begin
      passCount++;
      $display("pass %s: %0h:%08h", name, key, data);
    end
    allSeen = (names.size() == 0);
  endtask

  task automatic reportCounts();
    $display("tests: %0d passed, %0d failed", passCount, errorCount);
  endtask

  always @(posedge clk) begin
    if (reset) begin
      if (wbValid || storeValid) begin
        errorCount++;
        $display("a trace pulse appeared while reset was high");
      end
    end else if (storeValid) begin
      if (names.size() == 0) begin
        errorCount++;
        $display("a store appeared after the last expected event");
      end else begin
        checkEvent(1'b1, {24'b0, store.wordAddr}, store.data);
      end
    end else if (wbValid && names.size() != 0) begin
      checkEvent(1'b0, {27'b0, wb.rd}, wb.data); // jal self-loop links fall past the end
    end
  end

endmodule

//--- verif/controlChecker_checker.sv
// control FSM checker
// concurrent assertions on the state register and the control word
`timescale 1ns/10ps

module controlChecker (
  input logic                  clk,
  input logic                  reset,
  input logic [3:0]            state,
  input rv32Pkg::controlWord_t ctrl
);
  import rv32Pkg::*;

  localparam logic [3:0] FetchState = 4'd0; // first enum value of the FSM

  logic [2:0] sinceFetch; // cycles since the last fetch

  always_ff @(posedge clk) begin
    if (reset || state == FetchState) begin
      sinceFetch <= '0;
    end else begin
      sinceFetch <= sinceFetch + 3'd1;
    end
  end

  irWriteOnlyInFetch: assert property (@(posedge clk) disable iff (reset)
    ctrl.irWrite |-> state == FetchState)
    else $error("irWrite high outside fetch");

  noRegAndMemWrite: assert property (@(posedge clk) disable iff (reset)
    !(ctrl.regWrite && ctrl.memWrite))
    else $error("regWrite and memWrite high together");

  // the longest instructions (load, jalr) take five cycles
  fetchRecurs: assert property (@(posedge clk) disable iff (reset)
    sinceFetch < 3'd5)
    else $error("fetch did not recur within 5 cycles");

endmodule

bind controlFsm controlChecker i_controlChecker (
  .clk   (clk),
  .reset (reset),
  .state (state),
  .ctrl  (ctrl)
);

//--- verif/rv32Tb.sv
// testbench for the RV32I multicycle core
// downloads a program during reset and checks the trace events it produces
`timescale 1ns/10ps
`include "rv32_settings.svh"

module rv32Tb;
  import rv32Pkg::*;

  localparam int ClkPeriod = 4;
  localparam int ResetCycles = 16;
  localparam int CyclesPerInstr = 6;
  localparam int MaxWords = 64;
  localparam int MaxEvents = 32;

  logic clk, reset, loadEn;
  wordAddr_t loadAddr;
  logic [`XLEN-1:0] loadData;
  logic wbValid, storeValid, allSeen;
  wbEvent_t wb;
  storeEvent_t store;
  int errorCount;

  logic [31:0] progMem [MaxWords];
  int progLen;
  string expName [MaxEvents];
  bit expStore [MaxEvents];
  logic [31:0] expKey [MaxEvents];
  logic [31:0] expData [MaxEvents];
  int eventCount;

  rv32Multicycle i_rv32Multicycle (
    .clk        (clk),
    .reset      (reset),
    .loadEn     (loadEn),
    .loadAddr   (loadAddr),
    .loadData   (loadData),
    .wbValid    (wbValid),
    .wb         (wb),
    .storeValid (storeValid),
    .store      (store)
  );

  traceMonitor i_traceMonitor (
    .clk        (clk),
    .reset      (reset),
    .wbValid    (wbValid),
    .wb         (wb),
    .storeValid (storeValid),
    .store      (store),
    .allSeen    (allSeen),
    .errorCount (errorCount)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // small assembler for the RV32I formats
  function automatic logic [31:0] encR(int f7, int f3, int rd, int rs1, int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] encI(int op, int f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] encS(int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] encB(int rs1, int rs2, int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] encJ(int rd, int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic logic [31:0] encU(int op, int rd, int imm20);
    return {imm20[19:0], rd[4:0], op[6:0]};
  endfunction

  task automatic put(logic [31:0] instr);
    progMem[progLen] = instr;
    progLen++;
  endtask

  task automatic expectWb(string name, int rd, logic [31:0] data);
    expName[eventCount] = name;
    expStore[eventCount] = 1'b0;
    expKey[eventCount] = rd;
    expData[eventCount] = data;
    eventCount++;
  endtask

  task automatic expectStore(string name, int wordAddr, logic [31:0] data);
    expName[eventCount] = name;
    expStore[eventCount] = 1'b1;
    expKey[eventCount] = wordAddr;
    expData[eventCount] = data;
    eventCount++;
  endtask

  task automatic buildProgram();
    progLen = 0;
    put(encI('h13, 0, 1, 0, 5));             // 0x00 addi x1, x0, 5
    put(encI('h13, 0, 2, 0, -3));            // 0x04 addi x2, x0, -3
    put(encR(0, 0, 3, 1, 2));                // add x3
    put(encR('h20, 0, 4, 1, 2));             // sub x4
    put(encR(0, 7, 5, 1, 2));                // and x5
    put(encR(0, 6, 6, 1, 2));                // or x6
    put(encR(0, 4, 7, 1, 2));                // xor x7
    put(encR(0, 2, 8, 2, 1));                // slt x8, x2, x1
    put(encR(0, 3, 9, 2, 1));                // sltu x9, x2, x1
    put(encR(0, 1, 10, 1, 1));               // sll x10, x1, x1
    put(encR(0, 5, 11, 2, 1));               // srl x11, x2, x1
    put(encR('h20, 5, 12, 2, 1));            // sra x12, x2, x1
    put(encI('h13, 0, 0, 1, 7));             // 0x30 addi x0, x1, 7
    put(encR(0, 0, 13, 0, 1));               // add x13, x0, x1
    put(encU('h37, 14, 'h12345));            // 0x38 lui
    put(encU('h17, 15, 'h1));                // 0x3c auipc
    put(encI('h13, 0, 16, 0, 'h100));        // 0x40
    put(encS(1, 16, 8));                     // 0x44 sw x1, 8(x16)
    put(encI('h03, 2, 17, 16, 8));           // 0x48 lw x17, 8(x16)
    put(encB(1, 1, 8));                      // 0x4c beq taken
    put(encI('h13, 0, 18, 0, 1));            // skipped
    put(encB(1, 2, 8));                      // 0x54 beq not taken
    put(encI('h13, 0, 19, 0, 2));            // 0x58
    put(encJ(20, 8));                        // 0x5c jal x20, +8
    put(encI('h13, 0, 21, 0, 3));            // skipped
    put(encI('h13, 0, 22, 0, 113));          // 0x64
    put(encI('h67, 0, 23, 22, 4));           // 0x68 jalr x23, 4(x22) to 0x74
    put(encI('h13, 0, 24, 0, 9));            // skipped
    put(encI('h13, 0, 25, 0, 10));           // skipped
    put(encI('h13, 0, 26, 0, 11));           // 0x74
    put(encJ(0, 0));                         // 0x78 park here
  endtask

  task automatic buildEvents();
    eventCount = 0;
    expectWb("addi", 1, 32'd5);
    expectWb("addi neg", 2, 32'hFFFF_FFFD);
    expectWb("add", 3, 32'd2);
    expectWb("sub", 4, 32'd8);
    expectWb("and", 5, 32'd5);
    expectWb("or", 6, 32'hFFFF_FFFD);
    expectWb("xor", 7, 32'hFFFF_FFF8);
    expectWb("slt", 8, 32'd1);
    expectWb("sltu", 9, 32'd0);
    expectWb("sll", 10, 32'h0000_00A0);
    expectWb("srl", 11, 32'h07FF_FFFF);
    expectWb("sra", 12, 32'hFFFF_FFFF);
    expectWb("addi x0", 0, 32'd12);
    expectWb("x0 reads zero", 13, 32'd5);
    expectWb("lui", 14, 32'h1234_5000);
    expectWb("auipc", 15, 32'h0000_103C);
    expectWb("base addr", 16, 32'h0000_0100);
    expectStore("sw", 'h42, 32'd5);          // byte 0x108
    expectWb("lw", 17, 32'd5);
    expectWb("beq not taken", 19, 32'd2);
    expectWb("jal link", 20, 32'h0000_0060);
    expectWb("jalr base", 22, 32'd113);
    expectWb("jalr link", 23, 32'h0000_006C);
    expectWb("jalr target", 26, 32'd11);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    loadEn = 1'b0;
    loadAddr = '0;
    loadData = '0;
    buildProgram();
    buildEvents();
    for (int i = 0; i < eventCount; i++) begin
      i_traceMonitor.addExpected(expName[i], expStore[i], expKey[i], expData[i]);
    end
    for (int i = 0; i < progLen; i++) begin
      @(negedge clk);
      loadEn = 1'b1;
      loadAddr = wordAddr_t'(i);
      loadData = progMem[i];
    end
    @(negedge clk);
    loadEn = 1'b0;
    repeat (ResetCycles) @(negedge clk);
    reset = 1'b0;
    wait (allSeen);
    repeat (4) @(posedge clk); // room for a stray store
    i_traceMonitor.reportCounts();
    if (errorCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // watchdog sized from the download, reset and per-instruction budget
  initial begin
    int limitNs;
    #1;
    limitNs = (progLen + 1 + ResetCycles + CyclesPerInstr * progLen) * ClkPeriod;
    #(limitNs);
    $display("timeout: the expected trace events did not all arrive");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- sources.f
+incdir+logic
logic/rv32Pkg.sv
logic/controlFsm.sv
logic/aluDecoder.sv
logic/immExtend.sv
logic/alu.sv
logic/datapath.sv
logic/unifiedMemory.sv
logic/rv32Multicycle.sv
verif/traceMonitor.sv
verif/controlChecker_checker.sv
verif/rv32Tb.sv

//--- run.sh
#!/bin/sh
# build the RV32 multicycle testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module rv32Tb -f sources.f -o rv32Sim &&
./obj_dir/rv32Sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
